//--- compile.f
axi_pkg.sv
video_pkg.sv
frame_sync.sv
burst_addr_gen.sv
axi_write_engine.sv
axi_read_engine.sv
axi_frame_dma.sv
tb_axi_frame_dma.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_axi_frame_dma \
		-f compile.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	! grep -q "Simulation failed" sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb_axi_frame_dma.sv
`timescale 1ns/1ps

module tb_axi_frame_dma;

    localparam int unsigned IMAGE_WIDTH = 16;
    localparam int unsigned IMAGE_HIGH  = 4;
    localparam int unsigned BURST_LEN   = 4;
    localparam int unsigned DATA_W      = 128;
    localparam int unsigned BEAT_BYTES  = DATA_W / 8;
    localparam int unsigned BURST_BYTES = BURST_LEN * BEAT_BYTES;
    // 16-bit pixels
    localparam int unsigned FRAME_BYTES = IMAGE_WIDTH * IMAGE_HIGH * 2;
    // 16 bytes per beat
    localparam logic [2:0]  EXP_SIZE    = 3'd4;
    localparam int unsigned TIMEOUT     = 2000;

    logic              ui_clk;
    logic              Rst_INIT_DONE;
    logic              wr_clk;
    logic              awready, wready, bvalid, arready;
    logic              rlast, rvalid;
    logic [DATA_W-1:0] rdata;
    logic              wr_trigger, rd_trigger;
    logic              wr_frame_sync, rd_frame_sync;
    logic [DATA_W-1:0] wdata_fifo_rd_data;
    logic [32:0]       m_axi_awaddr, m_axi_araddr;
    logic [7:0]        m_axi_awlen, m_axi_arlen;
    logic [2:0]        m_axi_awsize, m_axi_arsize;
    logic [1:0]        m_axi_awburst, m_axi_arburst;
    logic              m_axi_awvalid, m_axi_arvalid;
    logic [DATA_W-1:0] m_axi_wdata;
    logic [15:0]       m_axi_wstrb;
    logic              m_axi_wlast, m_axi_wvalid, m_axi_bready, m_axi_rready;
    logic              wdata_fifo_rd_en, rdata_fifo_wr_en;
    logic [DATA_W-1:0] rdata_fifo_wr_data;

    int          seed       = 17681;
    int unsigned errors     = 0;
    int unsigned timeouts   = 0;
    int unsigned fifo_count = 0;
    int unsigned b_count    = 0;
    int unsigned r_count    = 0;
    int unsigned wr_expect  = 0;
    int unsigned rd_expect  = 0;
    string       cur_test   = "reset";

    logic [DATA_W-1:0] slave_mem [int unsigned];
    logic [DATA_W-1:0] exp_mem [int unsigned];
    logic [32:0]       aw_log [$];
    logic [32:0]       ar_log [$];
    logic [DATA_W-1:0] w_data_log [$];
    logic              w_last_log [$];
    logic [DATA_W-1:0] r_log [$];

    axi_frame_dma #(
        .BURST_LEN   (BURST_LEN),
        .DATA_W      (DATA_W),
        .IMAGE_WIDTH (IMAGE_WIDTH),
        .IMAGE_HIGH  (IMAGE_HIGH)
    ) u_axi_frame_dma (.*);

    initial begin
        ui_clk = 1'b0;
        forever #50 ui_clk = ~ui_clk;
    end

    // pixel clock unrelated to ui_clk
    initial begin
        wr_clk = 1'b0;
        forever #35 wr_clk = ~wr_clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [DATA_W-1:0] fifo_word(input int unsigned n);
        return {n, ~n, n ^ 32'h5a5a_5a5a, n + 32'h1000_0000};
    endfunction

    // unwritten locations read back an address pattern
    function automatic logic [DATA_W-1:0] read_word(input int unsigned addr);
        if (slave_mem.exists(addr)) return slave_mem[addr];
        return {4{addr ^ 32'hc3c3_0f0f}};
    endfunction

    function automatic logic random_ready();
        return ($random(seed) % 4) != 0;
    endfunction

    // sequential bursts that wrap to zero after the last one of the frame
    function automatic int unsigned next_burst_addr(input int unsigned addr);
        return (addr + BURST_BYTES >= FRAME_BYTES) ? 0 : addr + BURST_BYTES;
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s %s expected 0x%0h actual 0x%0h",
                     test, what, expected, actual);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // AXI slave memory and FIFO models
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic        aw_fire, w_fire, b_fire, ar_fire, r_fire;
        logic        b_pending;
        logic        r_active;
        int unsigned waddr, raddr, wbeat, rbeat;
        awready            = 1'b0;
        wready             = 1'b0;
        bvalid             = 1'b0;
        arready            = 1'b0;
        rvalid             = 1'b0;
        rlast              = 1'b0;
        rdata              = '0;
        wdata_fifo_rd_data = fifo_word(0);
        b_pending          = 1'b0;
        r_active           = 1'b0;
        waddr              = 0;
        raddr              = 0;
        wbeat              = 0;
        rbeat              = 0;
        forever begin
            @(negedge ui_clk);
            // handshakes the next rising edge takes
            aw_fire = m_axi_awvalid & awready;
            w_fire  = m_axi_wvalid & wready;
            b_fire  = bvalid & m_axi_bready;
            ar_fire = m_axi_arvalid & arready;
            r_fire  = rvalid & m_axi_rready;
            check_value(cur_test, "wdata_fifo_rd_en", w_fire, wdata_fifo_rd_en);
            check_value(cur_test, "rdata_fifo_wr_en", r_fire, rdata_fifo_wr_en);
            if (aw_fire) begin
                aw_log.push_back(m_axi_awaddr);
                waddr = int'(m_axi_awaddr);
                wbeat = 0;
            end
            if (w_fire) begin
                slave_mem[waddr + wbeat * BEAT_BYTES] = m_axi_wdata;
                w_data_log.push_back(m_axi_wdata);
                w_last_log.push_back(m_axi_wlast);
                wbeat++;
                if (m_axi_wlast) b_pending = 1'b1;
            end
            if (b_fire) b_count++;
            if (ar_fire) begin
                ar_log.push_back(m_axi_araddr);
                raddr    = int'(m_axi_araddr);
                rbeat    = 0;
                r_active = 1'b1;
            end
            if (r_fire) begin
                r_log.push_back(rdata_fifo_wr_data);
                rbeat++;
                if (rlast) begin
                    r_active = 1'b0;
                    r_count++;
                end
            end

            @(posedge ui_clk);
            #1;
            // FWFT fifo shows the next word after a read
            if (w_fire) fifo_count++;
            wdata_fifo_rd_data = fifo_word(fifo_count);
            awready = random_ready();
            wready  = random_ready();
            arready = random_ready();
            if (b_fire) begin
                bvalid    = 1'b0;
                b_pending = 1'b0;
            end else if (b_pending && !bvalid) begin
                bvalid = random_ready();
            end
            if (r_fire) begin
                rvalid = 1'b0;
                rlast  = 1'b0;
            end
            // a beat stays on the bus until it is taken
            if (r_active && !rvalid && random_ready()) begin
                rvalid = 1'b1;
                rdata  = read_word(raddr + rbeat * BEAT_BYTES);
                rlast  = (rbeat == BURST_LEN - 1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // burst sequences
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_write_burst();
        int unsigned first_word;
        int unsigned target;
        int unsigned cycles;
        int unsigned k;
        first_word = fifo_count;
        target     = b_count + 1;
        aw_log.delete();
        w_data_log.delete();
        w_last_log.delete();
        @(posedge ui_clk);
        #1;
        wr_trigger = 1'b1;
        @(posedge ui_clk);
        #1;
        wr_trigger = 1'b0;
        cycles = 0;
        while (b_count < target && cycles < TIMEOUT) begin
            @(posedge ui_clk);
            #1;
            cycles++;
        end
        if (b_count < target) begin
            $display("ERROR: %s timed out waiting for the write response", cur_test);
            timeouts++;
        end else begin
            check_value(cur_test, "aw count", 1, aw_log.size());
            if (aw_log.size() > 0) check_value(cur_test, "awaddr", wr_expect, aw_log[0]);
            check_value(cur_test, "w beats", BURST_LEN, w_data_log.size());
            for (k = 0; k < w_data_log.size() && k < BURST_LEN; k++) begin
                check_value(cur_test, "wdata", fifo_word(first_word + k), w_data_log[k]);
                check_value(cur_test, "wlast", k == BURST_LEN - 1, w_last_log[k]);
                exp_mem[wr_expect + k * BEAT_BYTES] = fifo_word(first_word + k);
            end
        end
        wr_expect = next_burst_addr(wr_expect);
    endtask

    task automatic run_read_burst();
        int unsigned target;
        int unsigned cycles;
        int unsigned k;
        int unsigned addr;
        target = r_count + 1;
        ar_log.delete();
        r_log.delete();
        @(posedge ui_clk);
        #1;
        rd_trigger = 1'b1;
        @(posedge ui_clk);
        #1;
        rd_trigger = 1'b0;
        cycles = 0;
        while (r_count < target && cycles < TIMEOUT) begin
            @(posedge ui_clk);
            #1;
            cycles++;
        end
        if (r_count < target) begin
            $display("ERROR: %s timed out waiting for the last read beat", cur_test);
            timeouts++;
        end else begin
            check_value(cur_test, "ar count", 1, ar_log.size());
            if (ar_log.size() > 0) check_value(cur_test, "araddr", rd_expect, ar_log[0]);
            check_value(cur_test, "r beats", BURST_LEN, r_log.size());
            for (k = 0; k < r_log.size() && k < BURST_LEN; k++) begin
                addr = rd_expect + k * BEAT_BYTES;
                if (!exp_mem.exists(addr)) begin
                    $display("ERROR: %s read address 0x%0h was never written", cur_test, addr);
                    errors++;
                end else begin
                    check_value(cur_test, "read fifo data", exp_mem[addr], r_log[k]);
                end
            end
        end
        rd_expect = next_burst_addr(rd_expect);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        cur_test = "reset_state";
        check_value(cur_test, "awvalid", 0, m_axi_awvalid);
        check_value(cur_test, "wvalid", 0, m_axi_wvalid);
        check_value(cur_test, "bready", 0, m_axi_bready);
        check_value(cur_test, "arvalid", 0, m_axi_arvalid);
        check_value(cur_test, "rready", 0, m_axi_rready);
        check_value(cur_test, "wdata_fifo_rd_en", 0, wdata_fifo_rd_en);
        check_value(cur_test, "rdata_fifo_wr_en", 0, rdata_fifo_wr_en);
        check_value(cur_test, "awaddr", 0, m_axi_awaddr);
        check_value(cur_test, "araddr", 0, m_axi_araddr);
        check_value(cur_test, "awlen", BURST_LEN - 1, m_axi_awlen);
        check_value(cur_test, "arlen", BURST_LEN - 1, m_axi_arlen);
        check_value(cur_test, "awsize", EXP_SIZE, m_axi_awsize);
        check_value(cur_test, "arsize", EXP_SIZE, m_axi_arsize);
        // INCR
        check_value(cur_test, "awburst", 1, m_axi_awburst);
        check_value(cur_test, "arburst", 1, m_axi_arburst);
        check_value(cur_test, "wstrb", {BEAT_BYTES{1'b1}}, m_axi_wstrb);
    endtask

    task automatic write_bursts();
        cur_test = "write_bursts";
        repeat (3) run_write_burst();
    endtask

    task automatic read_bursts();
        cur_test = "read_bursts";
        repeat (2) run_read_burst();
    endtask

    task automatic write_frame_restart();
        int unsigned cycles;
        cur_test = "write_frame_restart";
        run_write_burst();
        // park the engine mid-frame
        if (wr_expect == 0) run_write_burst();
        check_value(cur_test, "awaddr before sync", wr_expect, m_axi_awaddr);
        @(posedge wr_clk);
        #1;
        wr_frame_sync = 1'b1;
        @(posedge wr_clk);
        #1;
        wr_frame_sync = 1'b0;
        cycles = 0;
        while (m_axi_awaddr != 0 && cycles < TIMEOUT) begin
            @(posedge ui_clk);
            #1;
            cycles++;
        end
        if (m_axi_awaddr != 0) begin
            $display("ERROR: %s write address never returned to zero", cur_test);
            timeouts++;
        end
        check_value(cur_test, "awvalid", 0, m_axi_awvalid);
        check_value(cur_test, "wvalid", 0, m_axi_wvalid);
        check_value(cur_test, "bready", 0, m_axi_bready);
        wr_expect = 0;
        run_write_burst();
    endtask

    task automatic read_frame_restart();
        int unsigned cycles;
        cur_test = "read_frame_restart";
        run_read_burst();
        if (rd_expect == 0) run_read_burst();
        check_value(cur_test, "araddr before sync", rd_expect, m_axi_araddr);
        @(posedge ui_clk);
        #1;
        rd_frame_sync = 1'b1;
        repeat (2) @(posedge ui_clk);
        #1;
        rd_frame_sync = 1'b0;
        cycles = 0;
        while (m_axi_araddr != 0 && cycles < TIMEOUT) begin
            @(posedge ui_clk);
            #1;
            cycles++;
        end
        if (m_axi_araddr != 0) begin
            $display("ERROR: %s read address never returned to zero", cur_test);
            timeouts++;
        end
        check_value(cur_test, "arvalid", 0, m_axi_arvalid);
        check_value(cur_test, "rready", 0, m_axi_rready);
        rd_expect = 0;
        run_read_burst();
    endtask

    initial begin
        Rst_INIT_DONE = 1'b0;
        wr_trigger    = 1'b0;
        rd_trigger    = 1'b0;
        wr_frame_sync = 1'b0;
        rd_frame_sync = 1'b0;
        repeat (3) @(posedge ui_clk);
        #1;
        Rst_INIT_DONE = 1'b1;

        reset_state();
        write_bursts();
        read_bursts();
        write_frame_restart();
        read_frame_restart();

        $display("checks done: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- axi_frame_dma.sv
`timescale 1ns/1ps

module axi_frame_dma #(
    parameter int unsigned BURST_LEN   = 240,
    parameter int unsigned DATA_W      = 128,
    parameter int unsigned WR_ADDR_W   = 33,
    parameter int unsigned RD_ADDR_W   = 33,
    parameter int unsigned IMAGE_WIDTH = video_pkg::DEF_IMAGE_WIDTH,
    parameter int unsigned IMAGE_HIGH  = video_pkg::DEF_IMAGE_HIGH,
    parameter int unsigned STRETCH_LEN = 21
) (
    input  logic                           ui_clk,
    input  logic                           Rst_INIT_DONE,
    // aw
    input  logic                           awready,
    output logic [WR_ADDR_W-1:0]           m_axi_awaddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]  m_axi_awlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0] m_axi_awsize,
    output logic [axi_pkg::AXI_BURST_W-1:0] m_axi_awburst,
    output logic                           m_axi_awvalid,
    // w
    input  logic                           wready,
    output logic [DATA_W-1:0]              m_axi_wdata,
    output logic [DATA_W/8-1:0]            m_axi_wstrb,
    output logic                           m_axi_wlast,
    output logic                           m_axi_wvalid,
    // b
    input  logic                           bvalid,
    output logic                           m_axi_bready,
    // ar
    input  logic                           arready,
    output logic [RD_ADDR_W-1:0]           m_axi_araddr,
    output logic [axi_pkg::AXI_LEN_W-1:0]  m_axi_arlen,
    output logic [axi_pkg::AXI_SIZE_W-1:0] m_axi_arsize,
    output logic [axi_pkg::AXI_BURST_W-1:0] m_axi_arburst,
    output logic                           m_axi_arvalid,
    // r
    input  logic [DATA_W-1:0]              rdata,
    input  logic                           rlast,
    input  logic                           rvalid,
    output logic                           m_axi_rready,
    // write pixel fifo
    input  logic                           wr_trigger,
    input  logic [DATA_W-1:0]              wdata_fifo_rd_data,
    output logic                           wdata_fifo_rd_en,
    // read pixel fifo
    input  logic                           rd_trigger,
    output logic                           rdata_fifo_wr_en,
    output logic [DATA_W-1:0]              rdata_fifo_wr_data,
    // frame starts
    input  logic                           wr_clk,
    input  logic                           wr_frame_sync,
    input  logic                           rd_frame_sync
);

    import axi_pkg::*;
    import video_pkg::*;

    localparam int unsigned FRAME_BYTES = frame_bytes(IMAGE_WIDTH, IMAGE_HIGH);
    localparam int unsigned BURST_BYTES = BURST_LEN * DATA_W / 8;

    logic wr_frame_start;
    logic rd_frame_start;

    // address wrap only works on whole bursts
    if ((FRAME_BYTES % BURST_BYTES) != 0) begin : g_bad_geometry
        $error("frame of %0d bytes is not a multiple of %0d-byte bursts",
               FRAME_BYTES, BURST_BYTES);
    end

    ////////////////////////////////////////////////////////////////////////////
    // fixed burst shape, same for both directions
    ////////////////////////////////////////////////////////////////////////////

    assign m_axi_awlen   = AXI_LEN_W'(BURST_LEN - 1);
    assign m_axi_awsize  = axi_size_code(DATA_W);
    assign m_axi_awburst = AXI_BURST_INCR;
    assign m_axi_wstrb   = '1;

    assign m_axi_arlen   = AXI_LEN_W'(BURST_LEN - 1);
    assign m_axi_arsize  = axi_size_code(DATA_W);
    assign m_axi_arburst = AXI_BURST_INCR;

    frame_sync #(
        .STRETCH_LEN (STRETCH_LEN)
    ) u_frame_sync (
        .ui_clk         (ui_clk),
        .Rst_INIT_DONE  (Rst_INIT_DONE),
        .wr_clk         (wr_clk),
        .wr_frame_sync  (wr_frame_sync),
        .rd_frame_sync  (rd_frame_sync),
        .wr_frame_start (wr_frame_start),
        .rd_frame_start (rd_frame_start)
    );

    axi_write_engine #(
        .BURST_LEN   (BURST_LEN),
        .DATA_W      (DATA_W),
        .FRAME_BYTES (FRAME_BYTES),
        .addr_t      (logic [WR_ADDR_W-1:0])
    ) u_axi_write_engine (
        .ui_clk             (ui_clk),
        .Rst_INIT_DONE      (Rst_INIT_DONE),
        .wr_trigger         (wr_trigger),
        .frame_start        (wr_frame_start),
        .awready            (awready),
        .wready             (wready),
        .bvalid             (bvalid),
        .wdata_fifo_rd_data (wdata_fifo_rd_data),
        .awaddr             (m_axi_awaddr),
        .awvalid            (m_axi_awvalid),
        .wdata              (m_axi_wdata),
        .wlast              (m_axi_wlast),
        .wvalid             (m_axi_wvalid),
        .bready             (m_axi_bready),
        .wdata_fifo_rd_en   (wdata_fifo_rd_en)
    );

    axi_read_engine #(
        .BURST_LEN   (BURST_LEN),
        .DATA_W      (DATA_W),
        .FRAME_BYTES (FRAME_BYTES),
        .addr_t      (logic [RD_ADDR_W-1:0])
    ) u_axi_read_engine (
        .ui_clk             (ui_clk),
        .Rst_INIT_DONE      (Rst_INIT_DONE),
        .rd_trigger         (rd_trigger),
        .frame_start        (rd_frame_start),
        .arready            (arready),
        .rdata              (rdata),
        .rlast              (rlast),
        .rvalid             (rvalid),
        .araddr             (m_axi_araddr),
        .arvalid            (m_axi_arvalid),
        .rready             (m_axi_rready),
        .rdata_fifo_wr_en   (rdata_fifo_wr_en),
        .rdata_fifo_wr_data (rdata_fifo_wr_data)
    );

endmodule

//--- axi_read_engine.sv
`timescale 1ns/1ps

module axi_read_engine #(
    parameter int unsigned BURST_LEN   = 240,
    parameter int unsigned DATA_W      = 128,
    parameter int unsigned FRAME_BYTES =
        video_pkg::frame_bytes(video_pkg::DEF_IMAGE_WIDTH, video_pkg::DEF_IMAGE_HIGH),
    parameter type         addr_t      = logic [32:0]
) (
    input  logic              ui_clk,
    input  logic              Rst_INIT_DONE,
    input  logic              rd_trigger,
    input  logic              frame_start,
    input  logic              arready,
    input  logic [DATA_W-1:0] rdata,
    input  logic              rlast,
    input  logic              rvalid,
    output addr_t             araddr,
    output logic              arvalid,
    output logic              rready,
    output logic              rdata_fifo_wr_en,
    output logic [DATA_W-1:0] rdata_fifo_wr_data
);

    localparam int unsigned BURST_BYTES = BURST_LEN * DATA_W / 8;

    logic busy;
    logic start_burst;
    logic ar_hs;
    logic r_hs;
    logic r_last_hs;

    assign start_burst = rd_trigger & ~busy;
    assign ar_hs       = arvalid & arready;
    assign r_hs        = rvalid & rready;
    assign r_last_hs   = r_hs & rlast;

    // every accepted beat lands in the read fifo
    assign rdata_fifo_wr_en   = r_hs;
    assign rdata_fifo_wr_data = rdata;

    burst_addr_gen #(
        .addr_t      (addr_t),
        .BURST_BYTES (BURST_BYTES),
        .FRAME_BYTES (FRAME_BYTES)
    ) u_burst_addr_gen (
        .ui_clk        (ui_clk),
        .Rst_INIT_DONE (Rst_INIT_DONE),
        .clear         (frame_start),
        .advance       (ar_hs),
        .addr          (araddr)
    );

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            busy    <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else if (frame_start) begin
            busy    <= 1'b0;
            arvalid <= 1'b0;
            rready  <= 1'b0;
        end else begin
            // burst is done on the beat carrying rlast
            if (r_last_hs) begin
                busy <= 1'b0;
            end else if (start_burst) begin
                busy <= 1'b1;
            end

            if (ar_hs) begin
                arvalid <= 1'b0;
            end else if (start_burst) begin
                arvalid <= 1'b1;
            end

            if (r_last_hs) begin
                rready <= 1'b0;
            end else if (ar_hs) begin
                rready <= 1'b1;
            end
        end
    end

    a_rready_in_burst: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        rready |-> busy
    ) else $error("rready high with no read burst open");

endmodule

//--- axi_write_engine.sv
`timescale 1ns/1ps

module axi_write_engine #(
    parameter int unsigned BURST_LEN   = 240,
    parameter int unsigned DATA_W      = 128,
    parameter int unsigned FRAME_BYTES =
        video_pkg::frame_bytes(video_pkg::DEF_IMAGE_WIDTH, video_pkg::DEF_IMAGE_HIGH),
    parameter type         addr_t      = logic [32:0]
) (
    input  logic              ui_clk,
    input  logic              Rst_INIT_DONE,
    input  logic              wr_trigger,
    input  logic              frame_start,
    input  logic              awready,
    input  logic              wready,
    input  logic              bvalid,
    input  logic [DATA_W-1:0] wdata_fifo_rd_data,
    output addr_t             awaddr,
    output logic              awvalid,
    output logic [DATA_W-1:0] wdata,
    output logic              wlast,
    output logic              wvalid,
    output logic              bready,
    output logic              wdata_fifo_rd_en
);

    import axi_pkg::*;

    localparam int unsigned BURST_BYTES = BURST_LEN * DATA_W / 8;

    logic                 busy;
    logic [AXI_LEN_W-1:0] beat_cnt;
    logic                 start_burst;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 b_hs;

    assign start_burst = wr_trigger & ~busy;
    assign aw_hs       = awvalid & awready;
    assign w_hs        = wvalid & wready;
    assign b_hs        = bvalid & bready;

    // FWFT fifo, head word goes straight onto the bus
    assign wdata            = wdata_fifo_rd_data;
    assign wdata_fifo_rd_en = w_hs;
    assign wlast            = (beat_cnt == AXI_LEN_W'(BURST_LEN - 1));

    burst_addr_gen #(
        .addr_t      (addr_t),
        .BURST_BYTES (BURST_BYTES),
        .FRAME_BYTES (FRAME_BYTES)
    ) u_burst_addr_gen (
        .ui_clk        (ui_clk),
        .Rst_INIT_DONE (Rst_INIT_DONE),
        .clear         (frame_start),
        .advance       (aw_hs),
        .addr          (awaddr)
    );

    ////////////////////////////////////////////////////////////////////////////
    // burst control, one burst in flight
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            busy     <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            bready   <= 1'b0;
            beat_cnt <= '0;
        end else if (frame_start) begin
            // new frame aborts whatever is in progress
            busy     <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            bready   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (b_hs) begin
                busy <= 1'b0;
            end else if (start_burst) begin
                busy <= 1'b1;
            end

            if (aw_hs) begin
                awvalid <= 1'b0;
            end else if (start_burst) begin
                awvalid <= 1'b1;
            end

            // data phase opens once the address is accepted
            if (w_hs && wlast) begin
                wvalid <= 1'b0;
            end else if (aw_hs) begin
                wvalid <= 1'b1;
            end

            if (b_hs) begin
                bready <= 1'b0;
            end else if (w_hs && wlast) begin
                bready <= 1'b1;
            end

            if (w_hs) begin
                beat_cnt <= wlast ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // a new address never overlaps the response of the previous burst
    a_aw_not_with_b: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        !(awvalid && bready)
    ) else $error("awvalid and bready high together");

    a_w_in_burst: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        $rose(wvalid) |-> busy
    ) else $error("wvalid raised outside a burst");

endmodule

//--- burst_addr_gen.sv
`timescale 1ns/1ps

module burst_addr_gen #(
    parameter type         addr_t      = logic [32:0],
    parameter int unsigned BURST_BYTES = 3840,
    parameter int unsigned FRAME_BYTES = 4147200
) (
    input  logic  ui_clk,
    input  logic  Rst_INIT_DONE,
    input  logic  clear,
    input  logic  advance,
    output addr_t addr
);

    // start address of the final burst in a frame
    localparam addr_t LAST_ADDR = addr_t'(FRAME_BYTES - BURST_BYTES);
    localparam addr_t STEP      = addr_t'(BURST_BYTES);

    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            addr <= '0;
        end else if (clear) begin
            addr <= '0;
        end else if (advance) begin
            // back to the top of the frame after the last burst
            if (addr == LAST_ADDR) begin
                addr <= '0;
            end else begin
                addr <= addr + STEP;
            end
        end
    end

    // stays on a burst boundary inside the frame
    a_addr_in_frame: assert property (
        @(posedge ui_clk) disable iff (!Rst_INIT_DONE)
        ((addr % BURST_BYTES) == 0) && (addr <= LAST_ADDR)
    ) else $error("burst address %0d off grid or past frame end", addr);

endmodule

//--- frame_sync.sv
`timescale 1ns/1ps

module frame_sync #(
    parameter int unsigned STRETCH_LEN = 21
) (
    input  logic ui_clk,
    input  logic Rst_INIT_DONE,
    input  logic wr_clk,
    input  logic wr_frame_sync,
    input  logic rd_frame_sync,
    output logic wr_frame_start,
    output logic rd_frame_start
);

    logic [STRETCH_LEN-1:0] wr_stretch;
    logic                   wr_level;
    logic [2:0]             wr_level_sync;
    logic [2:0]             rd_sync;

    ////////////////////////////////////////////////////////////////////////////
    // write side, pixel clock domain
    ////////////////////////////////////////////////////////////////////////////

    // stretch the strobe so a slower ui_clk still catches it
    always_ff @(posedge wr_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            wr_stretch <= '0;
            wr_level   <= 1'b0;
        end else begin
            wr_stretch <= {wr_stretch[STRETCH_LEN-2:0], wr_frame_sync};
            // registered so no OR glitch crosses the boundary
            wr_level   <= |wr_stretch;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // ui_clk side
    ////////////////////////////////////////////////////////////////////////////

    // two sync stages, third flop for the edge
    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            wr_level_sync  <= '0;
            wr_frame_start <= 1'b0;
        end else begin
            wr_level_sync  <= {wr_level_sync[1:0], wr_level};
            wr_frame_start <= wr_level_sync[1] & ~wr_level_sync[2];
        end
    end

    // read strobe is already slow, plain 2-flop sync then edge
    always_ff @(posedge ui_clk or negedge Rst_INIT_DONE) begin
        if (!Rst_INIT_DONE) begin
            rd_sync        <= '0;
            rd_frame_start <= 1'b0;
        end else begin
            rd_sync        <= {rd_sync[1:0], rd_frame_sync};
            rd_frame_start <= rd_sync[1] & ~rd_sync[2];
        end
    end

endmodule

//--- video_pkg.sv
package video_pkg;

    // 16-bit pixels
    localparam int unsigned BYTES_PER_PIXEL = 2;

    // 1080p frame unless the top level says otherwise
    localparam int unsigned DEF_IMAGE_WIDTH = 1920;
    localparam int unsigned DEF_IMAGE_HIGH  = 1080;

    // bytes taken by one whole frame in DDR
    function automatic int unsigned frame_bytes(input int unsigned width,
                                                input int unsigned high);
        return width * high * BYTES_PER_PIXEL;
    endfunction

endpackage

//--- axi_pkg.sv
package axi_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // AXI4 field widths
    ////////////////////////////////////////////////////////////////////////////

    // AxLEN holds beats minus one
    localparam int unsigned AXI_LEN_W   = 8;
    localparam int unsigned AXI_SIZE_W  = 3;
    localparam int unsigned AXI_BURST_W = 2;

    ////////////////////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////////////////////

    // FIXED is 0, INCR is 1, WRAP is 2
    localparam logic [AXI_BURST_W-1:0] AXI_BURST_INCR = 2'b01;

    // AxSIZE is log2 of the bytes moved per beat
    function automatic logic [AXI_SIZE_W-1:0] axi_size_code(input int unsigned data_w);
        int unsigned bytes_per_beat;
        bytes_per_beat = data_w / 8;
        return AXI_SIZE_W'($clog2(bytes_per_beat));
    endfunction

endpackage
